/* run.sh */
#!/bin/sh
# Build and run the ooo_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ooo_core_tb -f tb.f -o ooo_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/ooo_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1

/* src/execute_unit.sv */
// physical register file and two-stage ALU, drives the writeback broadcast
module execute_unit #(
    parameter int NUM_PHYS_REGS = 24,
    localparam int PHYS_W = $clog2(NUM_PHYS_REGS)
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              issue_valid,
    input  ooo_pkg::op_t      issue_op,
    input  ooo_pkg::data_t    issue_imm,
    input  logic              issue_use_imm,
    input  logic [PHYS_W-1:0] issue_src1_tag,
    input  logic [PHYS_W-1:0] issue_src2_tag,
    input  logic [PHYS_W-1:0] issue_tag,
    output logic              wb_valid,
    output logic [PHYS_W-1:0] wb_tag,
    output ooo_pkg::data_t    wb_value
);

    ooo_pkg::data_t regfile [NUM_PHYS_REGS];

    // stage one, register read
    logic              s1_valid;
    ooo_pkg::op_t      s1_op;
    ooo_pkg::data_t    s1_imm;
    logic              s1_use_imm;
    logic [PHYS_W-1:0] s1_src1;
    logic [PHYS_W-1:0] s1_src2;
    logic [PHYS_W-1:0] s1_tag;

    // stage two, compute and broadcast
    logic              s2_valid;
    ooo_pkg::op_t      s2_op;
    ooo_pkg::data_t    s2_a;
    ooo_pkg::data_t    s2_b;
    logic [PHYS_W-1:0] s2_tag;

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_op      <= issue_op;
        s1_imm     <= issue_imm;
        s1_use_imm <= issue_use_imm;
        s1_src1    <= issue_src1_tag;
        s1_src2    <= issue_src2_tag;
        s1_tag     <= issue_tag;
        s2_op      <= s1_op;
        s2_tag     <= s1_tag;
        s2_a       <= regfile[s1_src1];
        s2_b       <= s1_use_imm ? s1_imm : regfile[s1_src2];
    end

    assign wb_valid = s2_valid;
    assign wb_tag   = s2_tag;
    assign wb_value = ooo_pkg::alu_result(s2_op, s2_a, s2_b);

    // all registers start at zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) regfile[i] <= '0;
        end else if (wb_valid) begin
            regfile[wb_tag] <= wb_value;
        end
    end

endmodule

/* src/inst_buffer.sv */
// instruction FIFO between the input port and rename, absorbs dispatch stalls
module inst_buffer #(
    parameter int IB_DEPTH = 4
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              in_valid,
    input  ooo_pkg::op_t      in_op,
    input  ooo_pkg::arch_idx_t in_dest,
    input  ooo_pkg::arch_idx_t in_src1,
    input  ooo_pkg::arch_idx_t in_src2,
    input  ooo_pkg::data_t    in_imm,
    input  logic              in_use_imm,
    output logic              in_ready,
    output logic              ib_valid,
    output ooo_pkg::op_t      ib_op,
    output ooo_pkg::arch_idx_t ib_dest,
    output ooo_pkg::arch_idx_t ib_src1,
    output ooo_pkg::arch_idx_t ib_src2,
    output ooo_pkg::data_t    ib_imm,
    output logic              ib_use_imm,
    input  logic              ib_ready
);

    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = $clog2(IB_DEPTH + 1);

    ooo_pkg::op_t       op_mem      [IB_DEPTH];
    ooo_pkg::arch_idx_t dest_mem    [IB_DEPTH];
    ooo_pkg::arch_idx_t src1_mem    [IB_DEPTH];
    ooo_pkg::arch_idx_t src2_mem    [IB_DEPTH];
    ooo_pkg::data_t     imm_mem     [IB_DEPTH];
    logic               use_imm_mem [IB_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready = (count != CNT_W'(IB_DEPTH));
    assign ib_valid = (count != '0);
    assign push     = in_valid && in_ready;
    assign pop      = ib_valid && ib_ready;

    assign ib_op      = op_mem[head];
    assign ib_dest    = dest_mem[head];
    assign ib_src1    = src1_mem[head];
    assign ib_src2    = src2_mem[head];
    assign ib_imm     = imm_mem[head];
    assign ib_use_imm = use_imm_mem[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= (tail == PTR_W'(IB_DEPTH - 1)) ? '0 : tail + 1'b1;
            if (pop) head <= (head == PTR_W'(IB_DEPTH - 1)) ? '0 : head + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            op_mem[tail]      <= in_op;
            dest_mem[tail]    <= in_dest;
            src1_mem[tail]    <= in_src1;
            src2_mem[tail]    <= in_src2;
            imm_mem[tail]     <= in_imm;
            use_imm_mem[tail] <= in_use_imm;
        end
    end

endmodule

/* src/issue_queue.sv */
// waiting instructions, wakeup from writeback, one ready entry issued per cycle
module issue_queue #(
    parameter int IQ_DEPTH      = 4,
    parameter int NUM_PHYS_REGS = 24,
    localparam int PHYS_W = $clog2(NUM_PHYS_REGS)
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  ooo_pkg::op_t      dispatch_op,
    input  ooo_pkg::data_t    dispatch_imm,
    input  logic              dispatch_use_imm,
    input  logic [PHYS_W-1:0] dispatch_tag,
    input  logic [PHYS_W-1:0] dispatch_src1_tag,
    input  logic [PHYS_W-1:0] dispatch_src2_tag,
    input  logic              dispatch_src1_ready,
    input  logic              dispatch_src2_ready,
    input  logic              wb_valid,
    input  logic [PHYS_W-1:0] wb_tag,
    output logic              iq_ready,
    output logic              issue_valid,
    output ooo_pkg::op_t      issue_op,
    output ooo_pkg::data_t    issue_imm,
    output logic              issue_use_imm,
    output logic [PHYS_W-1:0] issue_src1_tag,
    output logic [PHYS_W-1:0] issue_src2_tag,
    output logic [PHYS_W-1:0] issue_tag
);

    localparam int IDX_W = $clog2(IQ_DEPTH);

    logic [IQ_DEPTH-1:0] valid;
    logic [IQ_DEPTH-1:0] rdy1;
    logic [IQ_DEPTH-1:0] rdy2;
    ooo_pkg::op_t        op_q      [IQ_DEPTH];
    ooo_pkg::data_t      imm_q     [IQ_DEPTH];
    logic                use_imm_q [IQ_DEPTH];
    logic [PHYS_W-1:0]   tag_q     [IQ_DEPTH];
    logic [PHYS_W-1:0]   src1_q    [IQ_DEPTH];
    logic [PHYS_W-1:0]   src2_q    [IQ_DEPTH];

    logic [IDX_W-1:0] sel;      // lowest ready entry
    logic [IDX_W-1:0] alloc;    // lowest empty slot

    always_comb begin
        issue_valid = 1'b0;
        iq_ready    = 1'b0;
        sel         = '0;
        alloc       = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (valid[i] && rdy1[i] && rdy2[i]) begin
                issue_valid = 1'b1;
                sel         = IDX_W'(i);
            end
            if (!valid[i]) begin
                iq_ready = 1'b1;
                alloc    = IDX_W'(i);
            end
        end
    end

    assign issue_op       = op_q[sel];
    assign issue_imm      = imm_q[sel];
    assign issue_use_imm  = use_imm_q[sel];
    assign issue_src1_tag = src1_q[sel];
    assign issue_src2_tag = src2_q[sel];
    assign issue_tag      = tag_q[sel];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (issue_valid) valid[sel] <= 1'b0;
            if (dispatch_valid) valid[alloc] <= 1'b1;
        end
    end

    // wakeup first, a fresh entry overrides its own slot
    always_ff @(posedge clock) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (wb_valid && valid[i] && src1_q[i] == wb_tag) rdy1[i] <= 1'b1;
            if (wb_valid && valid[i] && src2_q[i] == wb_tag) rdy2[i] <= 1'b1;
        end
        if (dispatch_valid) begin
            op_q[alloc]      <= dispatch_op;
            imm_q[alloc]     <= dispatch_imm;
            use_imm_q[alloc] <= dispatch_use_imm;
            tag_q[alloc]     <= dispatch_tag;
            src1_q[alloc]    <= dispatch_src1_tag;
            src2_q[alloc]    <= dispatch_src2_tag;
            rdy1[alloc]      <= dispatch_src1_ready;
            rdy2[alloc]      <= dispatch_src2_ready;
        end
    end

endmodule

/* src/ooo_core.sv */
// top level of the scalar out-of-order core, sets the sizes and wires the stages
module ooo_core #(
    parameter int ROB_DEPTH     = 8,
    parameter int IQ_DEPTH      = 4,
    parameter int IB_DEPTH      = 4,
    parameter int NUM_PHYS_REGS = 24
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               in_valid,
    input  ooo_pkg::op_t       in_op,
    input  ooo_pkg::arch_idx_t in_dest,
    input  ooo_pkg::arch_idx_t in_src1,
    input  ooo_pkg::arch_idx_t in_src2,
    input  ooo_pkg::data_t     in_imm,
    input  logic               in_use_imm,
    output logic               in_ready,
    output logic               commit_valid,
    output ooo_pkg::arch_idx_t commit_dest,
    output ooo_pkg::data_t     commit_value,
    input  logic               commit_ready
);

    localparam int PHYS_W = $clog2(NUM_PHYS_REGS);

    ////////////////////////////////////////////////////////////
    // stage wires
    ////////////////////////////////////////////////////////////

    logic               ib_valid, ib_ready, ib_use_imm;
    ooo_pkg::op_t       ib_op;
    ooo_pkg::arch_idx_t ib_dest, ib_src1, ib_src2;
    ooo_pkg::data_t     ib_imm;

    logic               dispatch_valid, dispatch_use_imm;
    logic               dispatch_src1_ready, dispatch_src2_ready;
    ooo_pkg::arch_idx_t dispatch_dest;
    ooo_pkg::op_t       dispatch_op;
    ooo_pkg::data_t     dispatch_imm;
    logic [PHYS_W-1:0]  dispatch_tag, dispatch_old_tag;
    logic [PHYS_W-1:0]  dispatch_src1_tag, dispatch_src2_tag;
    logic               rob_ready, iq_ready;

    logic               issue_valid, issue_use_imm;
    ooo_pkg::op_t       issue_op;
    ooo_pkg::data_t     issue_imm;
    logic [PHYS_W-1:0]  issue_src1_tag, issue_src2_tag, issue_tag;

    logic               wb_valid;
    logic [PHYS_W-1:0]  wb_tag;
    ooo_pkg::data_t     wb_value;

    logic               free_valid;
    logic [PHYS_W-1:0]  free_tag;

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    inst_buffer #(.IB_DEPTH(IB_DEPTH)) ib_i (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_op(in_op), .in_dest(in_dest),
        .in_src1(in_src1), .in_src2(in_src2), .in_imm(in_imm),
        .in_use_imm(in_use_imm), .in_ready(in_ready),
        .ib_valid(ib_valid), .ib_op(ib_op), .ib_dest(ib_dest),
        .ib_src1(ib_src1), .ib_src2(ib_src2), .ib_imm(ib_imm),
        .ib_use_imm(ib_use_imm), .ib_ready(ib_ready)
    );

    rename_stage #(.NUM_PHYS_REGS(NUM_PHYS_REGS)) rename_i (
        .clock(clock), .reset(reset),
        .ib_valid(ib_valid), .ib_op(ib_op), .ib_dest(ib_dest),
        .ib_src1(ib_src1), .ib_src2(ib_src2), .ib_imm(ib_imm),
        .ib_use_imm(ib_use_imm), .ib_ready(ib_ready),
        .rob_ready(rob_ready), .iq_ready(iq_ready),
        .wb_valid(wb_valid), .wb_tag(wb_tag),
        .free_valid(free_valid), .free_tag(free_tag),
        .dispatch_valid(dispatch_valid), .dispatch_dest(dispatch_dest),
        .dispatch_tag(dispatch_tag), .dispatch_old_tag(dispatch_old_tag),
        .dispatch_op(dispatch_op), .dispatch_imm(dispatch_imm),
        .dispatch_use_imm(dispatch_use_imm),
        .dispatch_src1_tag(dispatch_src1_tag), .dispatch_src2_tag(dispatch_src2_tag),
        .dispatch_src1_ready(dispatch_src1_ready), .dispatch_src2_ready(dispatch_src2_ready)
    );

    issue_queue #(.IQ_DEPTH(IQ_DEPTH), .NUM_PHYS_REGS(NUM_PHYS_REGS)) iq_i (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dispatch_imm(dispatch_imm), .dispatch_use_imm(dispatch_use_imm),
        .dispatch_tag(dispatch_tag),
        .dispatch_src1_tag(dispatch_src1_tag), .dispatch_src2_tag(dispatch_src2_tag),
        .dispatch_src1_ready(dispatch_src1_ready), .dispatch_src2_ready(dispatch_src2_ready),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .iq_ready(iq_ready),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_imm(issue_imm),
        .issue_use_imm(issue_use_imm), .issue_src1_tag(issue_src1_tag),
        .issue_src2_tag(issue_src2_tag), .issue_tag(issue_tag)
    );

    execute_unit #(.NUM_PHYS_REGS(NUM_PHYS_REGS)) exec_i (
        .clock(clock), .reset(reset),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_imm(issue_imm),
        .issue_use_imm(issue_use_imm), .issue_src1_tag(issue_src1_tag),
        .issue_src2_tag(issue_src2_tag), .issue_tag(issue_tag),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH), .NUM_PHYS_REGS(NUM_PHYS_REGS)) rob_i (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_dest(dispatch_dest),
        .dispatch_tag(dispatch_tag), .dispatch_old_tag(dispatch_old_tag),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value),
        .rob_ready(rob_ready), .commit_valid(commit_valid),
        .commit_dest(commit_dest), .commit_value(commit_value),
        .commit_ready(commit_ready),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

/* src/ooo_pkg.sv */
// opcode type, widths and ALU function shared by every stage of the core
package ooo_pkg;

    localparam int DATA_W    = 32;
    localparam int ARCH_REGS = 8;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_li
    } op_t;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [DATA_W-1:0]            data_t;

    // b carries the immediate when the instruction uses one
    function automatic data_t alu_result(op_t op, data_t a, data_t b);
        case (op)
            op_add:  alu_result = a + b;
            op_sub:  alu_result = a - b;
            op_and:  alu_result = a & b;
            op_or:   alu_result = a | b;
            op_xor:  alu_result = a ^ b;
            default: alu_result = b;    // op_li
        endcase
    endfunction

endpackage

/* src/rename_stage.sv */
// map table, free list and busy table, decides whether the buffer head dispatches
module rename_stage #(
    parameter int NUM_PHYS_REGS = 24,
    localparam int PHYS_W = $clog2(NUM_PHYS_REGS)
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               ib_valid,
    input  ooo_pkg::op_t       ib_op,
    input  ooo_pkg::arch_idx_t ib_dest,
    input  ooo_pkg::arch_idx_t ib_src1,
    input  ooo_pkg::arch_idx_t ib_src2,
    input  ooo_pkg::data_t     ib_imm,
    input  logic               ib_use_imm,
    output logic               ib_ready,
    input  logic               rob_ready,
    input  logic               iq_ready,
    input  logic               wb_valid,
    input  logic [PHYS_W-1:0]  wb_tag,
    input  logic               free_valid,
    input  logic [PHYS_W-1:0]  free_tag,
    output logic               dispatch_valid,
    output ooo_pkg::arch_idx_t dispatch_dest,
    output logic [PHYS_W-1:0]  dispatch_tag,
    output logic [PHYS_W-1:0]  dispatch_old_tag,
    output ooo_pkg::op_t       dispatch_op,
    output ooo_pkg::data_t     dispatch_imm,
    output logic               dispatch_use_imm,
    output logic [PHYS_W-1:0]  dispatch_src1_tag,
    output logic [PHYS_W-1:0]  dispatch_src2_tag,
    output logic               dispatch_src1_ready,
    output logic               dispatch_src2_ready
);

    localparam int FL_DEPTH = NUM_PHYS_REGS - ooo_pkg::ARCH_REGS;
    localparam int FL_W     = $clog2(FL_DEPTH);
    localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);

    logic [PHYS_W-1:0]        map_table [ooo_pkg::ARCH_REGS];
    logic [NUM_PHYS_REGS-1:0] busy;

    logic [PHYS_W-1:0]   fl_mem [FL_DEPTH];
    logic [FL_W-1:0]     fl_head;
    logic [FL_W-1:0]     fl_tail;
    logic [FL_CNT_W-1:0] fl_count;

    ////////////////////////////////////////////////////////////
    // dispatch decision and lookup
    ////////////////////////////////////////////////////////////

    assign dispatch_valid = ib_valid && (fl_count != '0) && rob_ready && iq_ready;
    assign ib_ready       = dispatch_valid;

    assign dispatch_dest     = ib_dest;
    assign dispatch_tag      = fl_mem[fl_head];     // free list head becomes the new mapping
    assign dispatch_old_tag  = map_table[ib_dest];
    assign dispatch_op       = ib_op;
    assign dispatch_imm      = ib_imm;
    assign dispatch_use_imm  = ib_use_imm;
    assign dispatch_src1_tag = map_table[ib_src1];
    assign dispatch_src2_tag = map_table[ib_src2];

    // writeback of this very cycle counts too
    assign dispatch_src1_ready = !busy[dispatch_src1_tag] ||
                                 (wb_valid && wb_tag == dispatch_src1_tag);
    assign dispatch_src2_ready = !busy[dispatch_src2_tag] ||
                                 (wb_valid && wb_tag == dispatch_src2_tag);

    ////////////////////////////////////////////////////////////
    // state update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) map_table[i] <= PHYS_W'(i);
            for (int i = 0; i < FL_DEPTH; i++) fl_mem[i] <= PHYS_W'(ooo_pkg::ARCH_REGS + i);
            busy     <= '0;
            fl_head  <= '0;
            fl_tail  <= '0;     // list starts full, tail wrapped onto head
            fl_count <= FL_CNT_W'(FL_DEPTH);
        end else begin
            if (wb_valid) busy[wb_tag] <= 1'b0;
            if (dispatch_valid) begin
                map_table[ib_dest]  <= dispatch_tag;
                busy[dispatch_tag]  <= 1'b1;
                fl_head <= (fl_head == FL_W'(FL_DEPTH - 1)) ? '0 : fl_head + 1'b1;
            end
            if (free_valid) begin   // retired old mapping comes back
                fl_mem[fl_tail] <= free_tag;
                fl_tail <= (fl_tail == FL_W'(FL_DEPTH - 1)) ? '0 : fl_tail + 1'b1;
            end
            fl_count <= fl_count + FL_CNT_W'(free_valid) - FL_CNT_W'(dispatch_valid);
        end
    end

endmodule

/* src/reorder_buffer.sv */
// in-order retirement of completed instructions, commit port and register release
module reorder_buffer #(
    parameter int ROB_DEPTH     = 8,
    parameter int NUM_PHYS_REGS = 24,
    localparam int PHYS_W = $clog2(NUM_PHYS_REGS)
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_valid,
    input  ooo_pkg::arch_idx_t dispatch_dest,
    input  logic [PHYS_W-1:0]  dispatch_tag,
    input  logic [PHYS_W-1:0]  dispatch_old_tag,
    input  logic               wb_valid,
    input  logic [PHYS_W-1:0]  wb_tag,
    input  ooo_pkg::data_t     wb_value,
    output logic               rob_ready,
    output logic               commit_valid,
    output ooo_pkg::arch_idx_t commit_dest,
    output ooo_pkg::data_t     commit_value,
    input  logic               commit_ready,
    output logic               free_valid,
    output logic [PHYS_W-1:0]  free_tag
);

    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    ooo_pkg::arch_idx_t   rob_dest  [ROB_DEPTH];
    logic [PHYS_W-1:0]    rob_tag   [ROB_DEPTH];
    logic [PHYS_W-1:0]    rob_old   [ROB_DEPTH];
    ooo_pkg::data_t       rob_value [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] rob_done;

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             retire;

    assign rob_ready    = (count != CNT_W'(ROB_DEPTH));
    assign commit_valid = (count != '0) && rob_done[head];
    assign commit_dest  = rob_dest[head];
    assign commit_value = rob_value[head];
    assign retire       = commit_valid && commit_ready;
    assign free_valid   = retire;
    assign free_tag     = rob_old[head];   // previous mapping of this destination

    ////////////////////////////////////////////////////////////
    // pointers and completion
    ////////////////////////////////////////////////////////////

    // tags are unique in flight, so a match on a retired slot is harmless
    always_ff @(posedge clock) begin
        if (reset) begin
            rob_done <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (wb_valid && rob_tag[i] == wb_tag) rob_done[i] <= 1'b1;
            end
            if (dispatch_valid) begin
                rob_done[tail] <= 1'b0;
                tail <= (tail == PTR_W'(ROB_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (retire) head <= (head == PTR_W'(ROB_DEPTH - 1)) ? '0 : head + 1'b1;
            count <= count + CNT_W'(dispatch_valid) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (wb_valid && rob_tag[i] == wb_tag) rob_value[i] <= wb_value;
        end
        if (dispatch_valid) begin
            rob_dest[tail] <= dispatch_dest;
            rob_tag[tail]  <= dispatch_tag;
            rob_old[tail]  <= dispatch_old_tag;
        end
    end

endmodule

/* tb.f */
src/ooo_pkg.sv
src/inst_buffer.sv
src/rename_stage.sv
src/issue_queue.sv
src/execute_unit.sv
src/reorder_buffer.sv
src/ooo_core.sv
verif/ooo_core_tb.sv

/* verif/ooo_core_tb.sv */
// simulation top that checks every commit of ooo_core against an in-order model
module ooo_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROB_DEPTH     = 8;
    localparam int IQ_DEPTH      = 4;
    localparam int IB_DEPTH      = 4;
    localparam int NUM_PHYS_REGS = 24;
    localparam int NUM_CHAIN     = 24;
    localparam int NUM_RAND      = 300;
    localparam int FILL_WINDOW   = 40;     // cycles of offered input under back-pressure
    localparam int TOTAL_INSTS   = ooo_pkg::ARCH_REGS + NUM_CHAIN + ROB_DEPTH + IB_DEPTH + NUM_RAND;
    localparam int CYCLE_LIMIT   = 40 * TOTAL_INSTS + 200;

    logic               clock;
    logic               reset;
    logic               in_valid;
    ooo_pkg::op_t       in_op;
    ooo_pkg::arch_idx_t in_dest;
    ooo_pkg::arch_idx_t in_src1;
    ooo_pkg::arch_idx_t in_src2;
    ooo_pkg::data_t     in_imm;
    logic               in_use_imm;
    logic               in_ready;
    logic               commit_valid;
    ooo_pkg::arch_idx_t commit_dest;
    ooo_pkg::data_t     commit_value;
    logic               commit_ready;

    integer             seed = 32'h62097692;
    int                 errors = 0;
    int                 errors_before = 0;
    int                 commits = 0;
    int                 cycles = 0;
    logic               rand_commit = 1'b0;
    ooo_pkg::data_t     ref_regs [ooo_pkg::ARCH_REGS];
    ooo_pkg::data_t     result;
    ooo_pkg::arch_idx_t exp_dest [$];
    ooo_pkg::data_t     exp_value [$];

    ooo_core #(
        .ROB_DEPTH(ROB_DEPTH), .IQ_DEPTH(IQ_DEPTH),
        .IB_DEPTH(IB_DEPTH), .NUM_PHYS_REGS(NUM_PHYS_REGS)
    ) dut_i (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_op(in_op), .in_dest(in_dest),
        .in_src1(in_src1), .in_src2(in_src2), .in_imm(in_imm),
        .in_use_imm(in_use_imm), .in_ready(in_ready),
        .commit_valid(commit_valid), .commit_dest(commit_dest),
        .commit_value(commit_value), .commit_ready(commit_ready)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////

    // sequential semantics with the immediate as second operand when use_imm is set
    function automatic ooo_pkg::data_t model_result(ooo_pkg::op_t op, ooo_pkg::data_t a,
                                                    ooo_pkg::data_t b);
        case (op)
            ooo_pkg::op_add: model_result = a + b;
            ooo_pkg::op_sub: model_result = a - b;
            ooo_pkg::op_and: model_result = a & b;
            ooo_pkg::op_or:  model_result = a | b;
            ooo_pkg::op_xor: model_result = a ^ b;
            default:         model_result = b;
        endcase
    endfunction

    always @(posedge clock) begin
        if (!reset && commit_valid && commit_ready) begin
            commits++;
            assert (exp_dest.size() != 0) else begin
                $display("commit of r%0d at %0t with no instruction outstanding",
                         commit_dest, $time);
                errors++;
            end
            if (exp_dest.size() != 0) begin
                assert (commit_dest == exp_dest[0] && commit_value == exp_value[0]) else begin
                    $display("error %0t: commit r%0d = %h, expected r%0d = %h", $time,
                             commit_dest, commit_value, exp_dest[0], exp_value[0]);
                    errors++;
                end
                void'(exp_dest.pop_front());
                void'(exp_value.pop_front());
            end
        end
        if (!reset && in_valid && in_ready) begin   // model advances at the input handshake
            result = model_result(in_op, ref_regs[in_src1],
                                  in_use_imm ? in_imm : ref_regs[in_src2]);
            ref_regs[in_dest] = result;
            exp_dest.push_back(in_dest);
            exp_value.push_back(result);
        end
    end

    // a stalled commit must not change under the consumer
    hold_while_stalled: assert property (@(posedge clock) disable iff (reset)
        commit_valid && !commit_ready |=>
            commit_valid && $stable(commit_dest) && $stable(commit_value))
    else begin
        $display("error %0t: commit output changed while commit_ready was low", $time);
        errors++;
    end

    always @(posedge clock) begin
        if (rand_commit) commit_ready <= (rand_word() % 4) != 0;
    end

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles with %0d commits outstanding",
                 CYCLE_LIMIT, exp_dest.size());
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    task automatic present(ooo_pkg::op_t op, ooo_pkg::arch_idx_t dest, ooo_pkg::arch_idx_t src1,
                           ooo_pkg::arch_idx_t src2, ooo_pkg::data_t imm, logic use_imm);
        in_valid   <= 1'b1;
        in_op      <= op;
        in_dest    <= dest;
        in_src1    <= src1;
        in_src2    <= src2;
        in_imm     <= imm;
        in_use_imm <= use_imm;
    endtask

    task automatic present_random();
        logic [31:0] r;
        r = rand_word();
        present(ooo_pkg::op_t'(3'(r % 6)), r[10:8], r[13:11], r[16:14], rand_word(), r[17]);
    endtask

    // holds the instruction until the handshake edge
    task automatic send(ooo_pkg::op_t op, ooo_pkg::arch_idx_t dest, ooo_pkg::arch_idx_t src1,
                        ooo_pkg::arch_idx_t src2, ooo_pkg::data_t imm, logic use_imm);
        present(op, dest, src1, src2, imm, use_imm);
        do @(posedge clock); while (!in_ready);
    endtask

    task automatic idle(int n);
        in_valid <= 1'b0;
        repeat (n) @(posedge clock);
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        @(posedge clock);   // model has taken the last handshake
        while (exp_dest.size() != 0) @(posedge clock);
        repeat (5) @(posedge clock);   // no stray commits afterwards
    endtask

    task automatic report(string name);
        $display("%s finished with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin : main
        int          accepted;
        logic [31:0] r;
        ooo_pkg::arch_idx_t prev;
        for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) ref_regs[i] = '0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = ooo_pkg::op_add;
        in_dest      = '0;
        in_src1      = '0;
        in_src2      = '0;
        in_imm       = '0;
        in_use_imm   = 1'b0;
        commit_ready = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        @(posedge clock);
        assert (!commit_valid && in_ready) else begin
            $display("error %0t: after reset commit_valid=%b in_ready=%b", $time,
                     commit_valid, in_ready);
            errors++;
        end
        report("reset state");

        for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
            send(ooo_pkg::op_li, ooo_pkg::arch_idx_t'(i), '0, '0, rand_word(), 1'b1);
        end
        drain();
        report("load immediate to every register");

        prev = '0;
        for (int k = 0; k < NUM_CHAIN; k++) begin   // each op with and without immediate
            r = rand_word();
            send(ooo_pkg::op_t'(3'(k % 6)), r[2:0], prev, r[5:3], {24'h0, r[15:8]},
                 1'((k / 6) % 2));
            prev = r[2:0];
        end
        drain();
        report("dependency chains");

        commit_ready <= 1'b0;
        accepted = 0;
        present_random();
        repeat (FILL_WINDOW) begin
            @(posedge clock);
            if (in_ready) begin
                accepted++;
                present_random();
            end
        end
        in_valid <= 1'b0;
        assert (accepted == ROB_DEPTH + IB_DEPTH) else begin
            $display("error %0t: %0d instructions accepted under back-pressure, expected %0d",
                     $time, accepted, ROB_DEPTH + IB_DEPTH);
            errors++;
        end
        commit_ready <= 1'b1;
        drain();
        report("commit back-pressure");

        rand_commit = 1'b1;
        for (int k = 0; k < NUM_RAND; k++) begin
            r = rand_word();
            if (r[1:0] == 2'b00) idle(1 + int'(r[3:2]));
            present_random();
            do @(posedge clock); while (!in_ready);
        end
        rand_commit = 1'b0;
        commit_ready <= 1'b1;
        drain();
        report("random stream");

        $display("tests 5, commits %0d, errors %0d", commits, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
